// ==== Makefile ====
# Verilator build and run for the game state updater

VERILATOR ?= verilator
TOP       ?= tb_game_state_updater
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SRCS    := $(wildcard *.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bullet_bus_if.sv ====
`timescale 1ns/10ps

interface bullet_bus_if;
    import game_geometry_pkg::*;
    import game_control_pkg::*;

    // Current player row
    pos_t player_pos;

    // Per slot state and position
    bullet_color_e slot_color [NUM_BULLETS];
    col_t slot_x [NUM_BULLETS];
    pos_t slot_y [NUM_BULLETS];

    modport mover (
        output player_pos
    );

    // Spawn row comes from the player
    modport launcher (
        input  player_pos,
        output slot_color,
        output slot_x,
        output slot_y
    );

    // Result stage reads it all
    modport encoder (
        input player_pos,
        input slot_color,
        input slot_x,
        input slot_y
    );

endinterface

// ==== bullet_launcher.sv ====
`timescale 1ns/10ps

module bullet_launcher (
    input  logic           blockieee_clock,
    input  logic           rst,
    input  logic           bullet_tick,
    game_cmd_if.launcher   cmd,
    bullet_bus_if.launcher bus
);
    import game_geometry_pkg::*;
    import game_control_pkg::*;

    // Slot state and position
    bullet_color_e color_q [NUM_BULLETS];
    col_t          x_q [NUM_BULLETS];
    pos_t          y_q [NUM_BULLETS];

    // Next slot to fill
    slot_idx_t ptr_q;
    slot_idx_t ptr_next;
    logic      spawn;

    //////////////////////////////////////////////////////////////////////
    // Spawn decision
    //////////////////////////////////////////////////////////////////////

    // Only the slot under the pointer may take a new bullet
    // A busy slot drops the request and keeps the pointer
    assign spawn = cmd.fire && (color_q[ptr_q] == BULLET_NONE);

    // Round robin over the slots
    assign ptr_next = (ptr_q == slot_idx_t'(NUM_BULLETS - 1)) ? '0 : ptr_q + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Slot update on each bullet tick
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_BULLETS; i++) begin
                color_q[i] <= BULLET_NONE;
                x_q[i]     <= '0;
                y_q[i]     <= '0;
            end
            ptr_q <= '0;
        end else if (bullet_tick) begin
            // Move live bullets one column right
            for (int i = 0; i < NUM_BULLETS; i++) begin
                if (color_q[i] != BULLET_NONE) begin
                    if (x_q[i] < COL_LAST) begin
                        x_q[i] <= x_q[i] + 1'b1;
                    end else begin
                        // Off the right edge
                        color_q[i] <= BULLET_NONE;
                        x_q[i]     <= '0;
                        y_q[i]     <= '0;
                    end
                end
            end
            // Spawned slot was empty so the advance above left it alone
            if (spawn) begin
                color_q[ptr_q] <= cmd.fire_color;
                x_q[ptr_q]     <= COL_SPAWN;
                y_q[ptr_q]     <= bus.player_pos;
                ptr_q          <= ptr_next;
            end
        end
    end

    // Slots out to the result stage
    assign bus.slot_color = color_q;
    assign bus.slot_x     = x_q;
    assign bus.slot_y     = y_q;

endmodule

// ==== compile.f ====
game_geometry_pkg.sv
game_control_pkg.sv
game_cmd_if.sv
bullet_bus_if.sv
nunchuk_decoder.sv
game_tick_gen.sv
player_mover.sv
bullet_launcher.sv
display_encoder.sv
game_state_updater.sv
game_properties.sv
tb_game_state_updater.sv

// ==== display_encoder.sv ====
`timescale 1ns/10ps

module display_encoder (
    input  logic                    blockieee_clock,
    input  logic                    rst,
    bullet_bus_if.encoder           bus,
    output game_geometry_pkg::pos_t blockieee_pos,
    output logic [game_geometry_pkg::NUM_BULLETS-1:0][game_control_pkg::RGB_W-1:0] bullet_color,
    output game_geometry_pkg::col_t [game_geometry_pkg::NUM_BULLETS-1:0] bullet_x,
    output game_geometry_pkg::pos_t [game_geometry_pkg::NUM_BULLETS-1:0] bullet_y
);
    import game_geometry_pkg::*;
    import game_control_pkg::*;

    // Slot state to display colour
    function automatic logic [RGB_W-1:0] rgb_of(input bullet_color_e state);
        case (state)
            BULLET_BLUE:  return RGB_BLUE;
            BULLET_RED:   return RGB_RED;
            BULLET_GREEN: return RGB_GREEN;
            default:      return RGB_NONE;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Output registers for the VGA side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            blockieee_pos <= POS_RESET;
            for (int i = 0; i < NUM_BULLETS; i++) begin
                bullet_color[i] <= RGB_NONE;
                bullet_x[i]     <= '0;
                bullet_y[i]     <= '0;
            end
        end else begin
            blockieee_pos <= bus.player_pos;
            for (int i = 0; i < NUM_BULLETS; i++) begin
                bullet_color[i] <= rgb_of(bus.slot_color[i]);
                bullet_x[i]     <= bus.slot_x[i];
                bullet_y[i]     <= bus.slot_y[i];
            end
        end
    end

endmodule

// ==== game_cmd_if.sv ====
`timescale 1ns/10ps

interface game_cmd_if;
    import game_control_pkg::*;

    // Requested move direction, held every cycle
    move_dir_e dir;
    // Fire request level and its colour
    logic fire;
    bullet_color_e fire_color;

    // Decode stage drives everything
    modport decoder (
        output dir,
        output fire,
        output fire_color
    );

    // Player stage only needs the direction
    modport mover (
        input dir
    );

    // Bullet stage takes the fire request
    modport launcher (
        input fire,
        input fire_color
    );

endinterface

// ==== game_control_pkg.sv ====
package game_control_pkg;

    //////////////////////////////////////////////////////////////////////
    // Command encodings
    //////////////////////////////////////////////////////////////////////

    // Player move request
    typedef enum logic [1:0] {
        DIR_STEADY,
        DIR_UP,
        DIR_DOWN
    } move_dir_e;

    // Slot state doubles as the bullet colour
    typedef enum logic [1:0] {
        BULLET_NONE,
        BULLET_BLUE,
        BULLET_RED,
        BULLET_GREEN
    } bullet_color_e;

    //////////////////////////////////////////////////////////////////////
    // Nunchuk stick
    //////////////////////////////////////////////////////////////////////

    localparam int STICK_W = 8;
    // Reading with the stick at rest
    localparam logic [STICK_W-1:0] STICK_CENTER = 8'd128;
    // Dead zone either side of centre
    localparam logic [STICK_W-1:0] STICK_DEADBAND = 8'd20;

    // 12-bit RGB for the display, 4 bits per channel
    localparam int RGB_W = 12;
    localparam logic [RGB_W-1:0] RGB_NONE = 12'h000;
    localparam logic [RGB_W-1:0] RGB_BLUE = 12'h00F;
    localparam logic [RGB_W-1:0] RGB_RED = 12'hF00;
    localparam logic [RGB_W-1:0] RGB_GREEN = 12'h0F0;

endpackage

// ==== game_geometry_pkg.sv ====
package game_geometry_pkg;

    //////////////////////////////////////////////////////////////////////
    // Playfield size
    //////////////////////////////////////////////////////////////////////

    // Bullets in flight at once
    localparam int NUM_BULLETS = 3;

    // Row and column widths
    localparam int POS_W = 4;
    localparam int COL_W = 4;

    typedef logic [POS_W-1:0] pos_t;
    typedef logic [COL_W-1:0] col_t;
    typedef logic [$clog2(NUM_BULLETS)-1:0] slot_idx_t;

    // Player rows run 0 (top) to POS_MAX (bottom)
    localparam pos_t POS_MAX = 4'd10;
    localparam pos_t POS_RESET = 4'd5;

    // Bullets enter just right of the player
    localparam col_t COL_SPAWN = 4'd2;
    // Leaves the screen after this one
    localparam col_t COL_LAST = 4'd15;

    //////////////////////////////////////////////////////////////////////
    // Tick rates in clock cycles
    //////////////////////////////////////////////////////////////////////

    localparam int MOVE_TICK_DIV = 6;
    localparam int BULLET_TICK_DIV = 4;

    // Counter widths for the tick generator
    localparam int MOVE_CNT_W = $clog2(MOVE_TICK_DIV);
    localparam int BULLET_CNT_W = $clog2(BULLET_TICK_DIV);

endpackage

// ==== game_properties.sv ====
`timescale 1ns/10ps

module game_properties (
    input logic                    blockieee_clock,
    input logic                    rst,
    input game_geometry_pkg::pos_t blockieee_pos,
    input logic [game_geometry_pkg::NUM_BULLETS-1:0][game_control_pkg::RGB_W-1:0] bullet_color,
    input game_geometry_pkg::col_t [game_geometry_pkg::NUM_BULLETS-1:0] bullet_x
);
    import game_geometry_pkg::*;
    import game_control_pkg::*;

    // Failed assertions so far
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // Player row
    //////////////////////////////////////////////////////////////////////

    // Row stays on the playfield
    pos_max_a: assert property (@(posedge blockieee_clock) disable iff (rst)
        blockieee_pos <= POS_MAX)
        else begin
            $error("player row %0d is below the last row", blockieee_pos);
            fail_count++;
        end

    // At most one row per cycle
    pos_step_a: assert property (@(posedge blockieee_clock) disable iff (rst)
        (blockieee_pos == $past(blockieee_pos)) ||
        (blockieee_pos == $past(blockieee_pos) + 4'd1) ||
        (blockieee_pos + 4'd1 == $past(blockieee_pos)))
        else begin
            $error("player row jumped by more than one");
            fail_count++;
        end

    //////////////////////////////////////////////////////////////////////
    // Bullet slots
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_BULLETS; i++) begin : g_slot
        // Empty slot parks at column 0
        empty_col_a: assert property (@(posedge blockieee_clock) disable iff (rst)
            (bullet_color[i] == RGB_NONE) |-> (bullet_x[i] == '0))
            else begin
                $error("empty slot %0d has a nonzero column", i);
                fail_count++;
            end
        // Live bullet never sits left of the spawn column
        live_col_a: assert property (@(posedge blockieee_clock) disable iff (rst)
            (bullet_color[i] != RGB_NONE) |-> (bullet_x[i] >= COL_SPAWN))
            else begin
                $error("live slot %0d is left of the spawn column", i);
                fail_count++;
            end
    end

endmodule

bind game_state_updater game_properties u_props (
    .blockieee_clock (blockieee_clock),
    .rst             (rst),
    .blockieee_pos   (blockieee_pos),
    .bullet_color    (bullet_color),
    .bullet_x        (bullet_x)
);

// ==== game_state_updater.sv ====
`timescale 1ns/10ps

module game_state_updater (
    input  logic                                 blockieee_clock,
    input  logic                                 rst,
    // Nunchuk inputs
    input  logic [game_control_pkg::STICK_W-1:0] stick_y,
    input  logic                                 z,
    input  logic                                 c,
    // Player row
    output game_geometry_pkg::pos_t              blockieee_pos,
    // Per slot bullet colour and position
    output logic [game_geometry_pkg::NUM_BULLETS-1:0][game_control_pkg::RGB_W-1:0] bullet_color,
    output game_geometry_pkg::col_t [game_geometry_pkg::NUM_BULLETS-1:0] bullet_x,
    output game_geometry_pkg::pos_t [game_geometry_pkg::NUM_BULLETS-1:0] bullet_y
);

    // Pacing strobes
    logic move_tick;
    logic bullet_tick;

    game_cmd_if   cmd_if ();
    bullet_bus_if bus_if ();

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    nunchuk_decoder u_decoder (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .stick_y         (stick_y),
        .z               (z),
        .c               (c),
        .cmd             (cmd_if.decoder)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    game_tick_gen u_ticks (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .move_tick       (move_tick),
        .bullet_tick     (bullet_tick)
    );

    player_mover u_mover (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .move_tick       (move_tick),
        .cmd             (cmd_if.mover),
        .bus             (bus_if.mover)
    );

    bullet_launcher u_launcher (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .bullet_tick     (bullet_tick),
        .cmd             (cmd_if.launcher),
        .bus             (bus_if.launcher)
    );

    // Result stage to the display
    display_encoder u_encoder (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .bus             (bus_if.encoder),
        .blockieee_pos   (blockieee_pos),
        .bullet_color    (bullet_color),
        .bullet_x        (bullet_x),
        .bullet_y        (bullet_y)
    );

endmodule

// ==== game_tick_gen.sv ====
`timescale 1ns/10ps

module game_tick_gen (
    input  logic blockieee_clock,
    input  logic rst,
    output logic move_tick,
    output logic bullet_tick
);
    import game_geometry_pkg::*;

    logic [MOVE_CNT_W-1:0]   move_cnt;
    logic [BULLET_CNT_W-1:0] bullet_cnt;

    //////////////////////////////////////////////////////////////////////
    // Tick strobes
    //////////////////////////////////////////////////////////////////////

    // High for one cycle at the top of each count
    assign move_tick   = (move_cnt == MOVE_CNT_W'(MOVE_TICK_DIV - 1));
    assign bullet_tick = (bullet_cnt == BULLET_CNT_W'(BULLET_TICK_DIV - 1));

    // Free running counters
    // Wrap in the same cycle the strobe fires
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            move_cnt   <= '0;
            bullet_cnt <= '0;
        end else begin
            if (move_tick) begin
                move_cnt <= '0;
            end else begin
                move_cnt <= move_cnt + 1'b1;
            end
            if (bullet_tick) begin
                bullet_cnt <= '0;
            end else begin
                bullet_cnt <= bullet_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== nunchuk_decoder.sv ====
`timescale 1ns/10ps

module nunchuk_decoder (
    input  logic                                 blockieee_clock,
    input  logic                                 rst,
    input  logic [game_control_pkg::STICK_W-1:0] stick_y,
    input  logic                                 z,
    input  logic                                 c,
    game_cmd_if.decoder                          cmd
);
    import game_control_pkg::*;

    move_dir_e     dir_d;
    bullet_color_e color_d;

    // Stick outside the dead zone picks a direction
    // High reading means stick pushed up
    always_comb begin
        if (stick_y > STICK_CENTER + STICK_DEADBAND) begin
            dir_d = DIR_UP;
        end else if (stick_y < STICK_CENTER - STICK_DEADBAND) begin
            dir_d = DIR_DOWN;
        end else begin
            dir_d = DIR_STEADY;
        end
    end

    // Button combination sets the colour
    always_comb begin
        case ({z, c})
            2'b10:   color_d = BULLET_BLUE;
            2'b01:   color_d = BULLET_RED;
            2'b11:   color_d = BULLET_GREEN;
            default: color_d = BULLET_NONE;
        endcase
    end

    // One register stage between the Nunchuk and the game
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            cmd.dir        <= DIR_STEADY;
            cmd.fire       <= 1'b0;
            cmd.fire_color <= BULLET_NONE;
        end else begin
            cmd.dir        <= dir_d;
            cmd.fire       <= z | c;
            cmd.fire_color <= color_d;
        end
    end

endmodule

// ==== player_mover.sv ====
`timescale 1ns/10ps

module player_mover (
    input  logic        blockieee_clock,
    input  logic        rst,
    input  logic        move_tick,
    game_cmd_if.mover   cmd,
    bullet_bus_if.mover bus
);
    import game_geometry_pkg::*;
    import game_control_pkg::*;

    // Player row, 0 is the top of the screen
    pos_t pos_q;

    //////////////////////////////////////////////////////////////////////
    // Row stepping
    //////////////////////////////////////////////////////////////////////

    // One step per move tick
    // Clamped at both edges of the field
    always_ff @(posedge blockieee_clock) begin
        if (rst) begin
            pos_q <= POS_RESET;
        end else if (move_tick) begin
            case (cmd.dir)
                DIR_UP: begin
                    // Up means a smaller row number
                    if (pos_q != '0) begin
                        pos_q <= pos_q - 1'b1;
                    end
                end
                DIR_DOWN: begin
                    if (pos_q < POS_MAX) begin
                        pos_q <= pos_q + 1'b1;
                    end
                end
                default: begin
                    pos_q <= pos_q;
                end
            endcase
        end
    end

    // Shared with the bullet and display stages
    assign bus.player_pos = pos_q;

endmodule

// ==== tb_game_state_updater.sv ====
`timescale 1ns/10ps

module tb_game_state_updater;
    import game_geometry_pkg::*;
    import game_control_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    // Random stimulus stops here
    localparam int RANDOM_END = 1900;
    // Longest wait for a slot to change, a full flight plus margin
    localparam int WAIT_LIMIT = 100;

    // Expected register state of the whole design
    typedef struct packed {
        logic [1:0]                         dir;
        logic                               fire;
        logic [1:0]                         fire_color;
        logic [2:0]                         move_cnt;
        logic [1:0]                         bullet_cnt;
        pos_t                               pos;
        logic [NUM_BULLETS-1:0][1:0]        slot_color;
        col_t [NUM_BULLETS-1:0]             slot_x;
        pos_t [NUM_BULLETS-1:0]             slot_y;
        slot_idx_t                          ptr;
        pos_t                               out_pos;
        logic [NUM_BULLETS-1:0][RGB_W-1:0]  out_color;
        col_t [NUM_BULLETS-1:0]             out_x;
        pos_t [NUM_BULLETS-1:0]             out_y;
    } model_t;

    logic                              blockieee_clock;
    logic                              rst;
    logic [7:0]                        stick_y;
    logic                              z;
    logic                              c;
    pos_t                              blockieee_pos;
    logic [NUM_BULLETS-1:0][RGB_W-1:0] bullet_color;
    col_t [NUM_BULLETS-1:0]            bullet_x;
    pos_t [NUM_BULLETS-1:0]            bullet_y;

    model_t model;
    logic   checking;
    int     error_count;
    int     check_count;
    int     cycle_count;
    integer seed;

    game_state_updater u_dut (
        .blockieee_clock (blockieee_clock),
        .rst             (rst),
        .stick_y         (stick_y),
        .z               (z),
        .c               (c),
        .blockieee_pos   (blockieee_pos),
        .bullet_color    (bullet_color),
        .bullet_x        (bullet_x),
        .bullet_y        (bullet_y)
    );

    // 20 ns period
    initial blockieee_clock = 1'b0;
    always #10 blockieee_clock = ~blockieee_clock;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [RGB_W-1:0] expected_rgb(input logic [1:0] state);
        case (state)
            BULLET_BLUE:  return 12'h00F;
            BULLET_RED:   return 12'hF00;
            BULLET_GREEN: return 12'h0F0;
            default:      return 12'h000;
        endcase
    endfunction

    // All zero is steady, no fire, empty slots, pointer at slot 0
    function automatic model_t reset_model();
        model_t m;
        m = '0;
        m.pos = 4'd5;
        m.out_pos = 4'd5;
        return m;
    endfunction

    // Next state after one clock edge, all stages read the old state
    function automatic model_t step_model(input model_t s, input logic [7:0] sy,
                                          input logic zi, input logic ci);
        model_t n;
        logic   mt;
        logic   bt;
        n = s;
        mt = (s.move_cnt == 3'(MOVE_TICK_DIV - 1));
        bt = (s.bullet_cnt == 2'(BULLET_TICK_DIV - 1));
        // Decoder register
        if (int'(sy) > int'(STICK_CENTER) + int'(STICK_DEADBAND)) begin
            n.dir = DIR_UP;
        end else if (int'(sy) < int'(STICK_CENTER) - int'(STICK_DEADBAND)) begin
            n.dir = DIR_DOWN;
        end else begin
            n.dir = DIR_STEADY;
        end
        n.fire = zi | ci;
        case ({zi, ci})
            2'b10:   n.fire_color = BULLET_BLUE;
            2'b01:   n.fire_color = BULLET_RED;
            2'b11:   n.fire_color = BULLET_GREEN;
            default: n.fire_color = BULLET_NONE;
        endcase
        // Tick counters
        n.move_cnt = mt ? 3'd0 : s.move_cnt + 3'd1;
        n.bullet_cnt = bt ? 2'd0 : s.bullet_cnt + 2'd1;
        // Player row, clamped to 0..10
        if (mt && s.dir == DIR_UP && s.pos != 4'd0) begin
            n.pos = s.pos - 4'd1;
        end else if (mt && s.dir == DIR_DOWN && s.pos < 4'd10) begin
            n.pos = s.pos + 4'd1;
        end
        if (bt) begin
            for (int i = 0; i < NUM_BULLETS; i++) begin
                if (s.slot_color[i] != BULLET_NONE && s.slot_x[i] < 4'd15) begin
                    n.slot_x[i] = s.slot_x[i] + 4'd1;
                end else if (s.slot_color[i] != BULLET_NONE) begin
                    n.slot_color[i] = BULLET_NONE;
                    n.slot_x[i] = 4'd0;
                    n.slot_y[i] = 4'd0;
                end
            end
            // Spawn only into a slot that was empty before this tick
            if (s.fire && s.slot_color[s.ptr] == BULLET_NONE) begin
                n.slot_color[s.ptr] = s.fire_color;
                n.slot_x[s.ptr] = 4'd2;
                n.slot_y[s.ptr] = s.pos;
                n.ptr = (s.ptr == 2'd2) ? 2'd0 : s.ptr + 2'd1;
            end
        end
        // Display registers
        n.out_pos = s.pos;
        for (int i = 0; i < NUM_BULLETS; i++) begin
            n.out_color[i] = expected_rgb(s.slot_color[i]);
            n.out_x[i] = s.slot_x[i];
            n.out_y[i] = s.slot_y[i];
        end
        return n;
    endfunction

    always @(posedge blockieee_clock) begin
        cycle_count++;
        if (rst) begin
            model = reset_model();
            checking = 1'b1;
        end else begin
            model = step_model(model, stick_y, z, c);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Cycle by cycle comparison and timeout
    //////////////////////////////////////////////////////////////////////

    // Outputs are stable at the falling edge
    always @(negedge blockieee_clock) begin
        if (checking) begin
            check_count++;
            if (blockieee_pos !== model.out_pos) begin
                error_count++;
                $display("Error: time %0t, blockieee_pos is %0d, expected %0d",
                         $time, blockieee_pos, model.out_pos);
            end
            for (int i = 0; i < NUM_BULLETS; i++) begin
                if (bullet_color[i] !== model.out_color[i]) begin
                    error_count++;
                    $display("Error: time %0t, bullet_color[%0d] is %h, expected %h",
                             $time, i, bullet_color[i], model.out_color[i]);
                end
                if (bullet_x[i] !== model.out_x[i] || bullet_y[i] !== model.out_y[i]) begin
                    error_count++;
                    $display("Error: time %0t, slot %0d at x %0d y %0d, expected x %0d y %0d",
                             $time, i, bullet_x[i], bullet_y[i], model.out_x[i], model.out_y[i]);
                end
            end
        end
    end

    // Cycle count is settled away from the rising edge
    always @(negedge blockieee_clock) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic drive_inputs(input logic [7:0] sy, input logic zi, input logic ci);
        stick_y = sy;
        z = zi;
        c = ci;
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) @(negedge blockieee_clock);
    endtask

    task automatic check_equal(input string what, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("Error: time %0t, %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // Wait until a slot is live or empty
    task automatic wait_for_slot(input int idx, input logic live);
        int waited;
        waited = 0;
        while ((bullet_color[idx] != 12'h000) != live && waited < WAIT_LIMIT) begin
            @(negedge blockieee_clock);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            error_count++;
            $display("Slot %0d did not become %s within %0d cycles",
                     idx, live ? "live" : "empty", WAIT_LIMIT);
        end
    endtask

    // Follow one bullet until it leaves the screen
    task automatic track_bullet(input int idx);
        logic [3:0] prev;
        int         waited;
        prev = bullet_x[idx];
        waited = 0;
        while (bullet_color[idx] != 12'h000 && waited < WAIT_LIMIT) begin
            @(negedge blockieee_clock);
            waited++;
            if (bullet_color[idx] != 12'h000 && bullet_x[idx] != prev) begin
                check_equal("bullet column step", int'(bullet_x[idx]), int'(prev) + 1);
                prev = bullet_x[idx];
            end
        end
        if (waited >= WAIT_LIMIT) begin
            error_count++;
            $display("Bullet in slot %0d never left the screen", idx);
        end else begin
            check_equal("last bullet column", int'(prev), 15);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [7:0]  sy;
        int          span;
        int          held_pos;
        seed = 32'h095ac9c4;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        checking = 1'b0;
        rst = 1'b1;
        drive_inputs(8'd128, 1'b0, 1'b0);
        hold_cycles(3);
        rst = 1'b0;

        // Reset values
        check_equal("row after reset", int'(blockieee_pos), 5);
        for (int i = 0; i < NUM_BULLETS; i++) begin
            check_equal("colour after reset", int'(bullet_color[i]), 0);
        end

        // Stick extremes run the row into both edges
        drive_inputs(8'hFF, 1'b0, 1'b0);
        hold_cycles(80);
        check_equal("row with stick up", int'(blockieee_pos), 0);
        drive_inputs(8'h00, 1'b0, 1'b0);
        hold_cycles(80);
        check_equal("row with stick down", int'(blockieee_pos), 10);

        // Part way up, then the deadband holds the row
        drive_inputs(8'hFF, 1'b0, 1'b0);
        hold_cycles(20);
        drive_inputs(8'd128, 1'b0, 1'b0);
        hold_cycles(10);
        held_pos = int'(blockieee_pos);
        drive_inputs(8'd140, 1'b0, 1'b0);
        hold_cycles(20);
        drive_inputs(8'd110, 1'b0, 1'b0);
        hold_cycles(20);
        check_equal("row inside deadband", int'(blockieee_pos), held_pos);

        // One bullet per colour, one bullet tick of fire each
        drive_inputs(8'd128, 1'b1, 1'b0);
        hold_cycles(4);
        drive_inputs(8'd128, 1'b0, 1'b0);
        wait_for_slot(0, 1'b1);
        check_equal("blue colour", int'(bullet_color[0]), 12'h00F);
        check_equal("spawn column", int'(bullet_x[0]), 2);
        check_equal("spawn row", int'(bullet_y[0]), held_pos);
        drive_inputs(8'd128, 1'b0, 1'b1);
        hold_cycles(4);
        drive_inputs(8'd128, 1'b0, 1'b0);
        wait_for_slot(1, 1'b1);
        check_equal("red colour", int'(bullet_color[1]), 12'hF00);
        check_equal("spawn column", int'(bullet_x[1]), 2);
        drive_inputs(8'd128, 1'b1, 1'b1);
        hold_cycles(4);
        drive_inputs(8'd128, 1'b0, 1'b0);
        wait_for_slot(2, 1'b1);
        check_equal("green colour", int'(bullet_color[2]), 12'h0F0);
        check_equal("spawn row", int'(bullet_y[2]), held_pos);
        track_bullet(0);
        wait_for_slot(1, 1'b0);
        wait_for_slot(2, 1'b0);

        // Held fire fills the slots in order, then waits on slot 0
        drive_inputs(8'd128, 1'b1, 1'b0);
        wait_for_slot(0, 1'b1);
        check_equal("slot 1 before its turn", int'(bullet_color[1]), 0);
        check_equal("slot 2 before its turn", int'(bullet_color[2]), 0);
        wait_for_slot(1, 1'b1);
        check_equal("slot 2 before its turn", int'(bullet_color[2]), 0);
        wait_for_slot(2, 1'b1);
        wait_for_slot(0, 1'b0);
        wait_for_slot(0, 1'b1);
        check_equal("respawn column", int'(bullet_x[0]), 2);
        drive_inputs(8'd128, 1'b0, 1'b0);

        // Random spans, extremes weighted up
        while (cycle_count < RANDOM_END) begin
            r = $random(seed);
            case (r[9:8])
                2'd0:    sy = 8'hFF;
                2'd1:    sy = 8'h00;
                default: sy = r[7:0];
            endcase
            span = int'(r[19:16]) + 1;
            drive_inputs(sy, r[12], r[13]);
            hold_cycles(span);
        end
        drive_inputs(8'd128, 1'b0, 1'b0);
        hold_cycles(4);

        // Bound assertion failures
        error_count += u_dut.u_props.fail_count;

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
